// File: isa_pkg.sv
`default_nettype none

package isa_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [31:0] inst_t;

  // Opcode field types
  typedef logic [5:0]  op6_t;
  typedef logic [6:0]  op7_t;
  typedef logic [9:0]  op10_t;
  typedef logic [16:0] op17_t;

  // Field positions in the instruction word
  localparam int RD_LSB    = 0;
  localparam int RJ_LSB    = 5;
  localparam int RK_LSB    = 10;
  localparam int IMM10_LSB = 0;
  localparam int IMM12_LSB = 10;
  localparam int IMM16_LSB = 10;
  localparam int IMM20_LSB = 5;
  localparam int OP6_LSB   = 26;
  localparam int OP7_LSB   = 25;
  localparam int OP10_LSB  = 22;
  localparam int OP17_LSB  = 15;

  // Branches and jumps
  localparam op6_t OP6_JIRL = 6'h13;
  localparam op6_t OP6_B    = 6'h14;
  localparam op6_t OP6_BL   = 6'h15;
  localparam op6_t OP6_BEQ  = 6'h16;
  localparam op6_t OP6_BNE  = 6'h17;
  localparam op6_t OP6_BLT  = 6'h18;
  localparam op6_t OP6_BGE  = 6'h19;
  localparam op6_t OP6_BLTU = 6'h1a;
  localparam op6_t OP6_BGEU = 6'h1b;

  localparam op7_t OP7_LU12I_W   = 7'h0a;
  localparam op7_t OP7_PCADDU12I = 7'h0e;

  // 12-bit immediate ALU, loads and stores
  localparam op10_t OP10_SLTI   = 10'h008;
  localparam op10_t OP10_SLTUI  = 10'h009;
  localparam op10_t OP10_ADDI_W = 10'h00a;
  localparam op10_t OP10_ANDI   = 10'h00d;
  localparam op10_t OP10_ORI    = 10'h00e;
  localparam op10_t OP10_XORI   = 10'h00f;
  localparam op10_t OP10_LD_B   = 10'h0a0;
  localparam op10_t OP10_LD_H   = 10'h0a1;
  localparam op10_t OP10_LD_W   = 10'h0a2;
  localparam op10_t OP10_ST_B   = 10'h0a4;
  localparam op10_t OP10_ST_H   = 10'h0a5;
  localparam op10_t OP10_ST_W   = 10'h0a6;
  localparam op10_t OP10_LD_BU  = 10'h0a8;
  localparam op10_t OP10_LD_HU  = 10'h0a9;

  // Register-register ALU and shift immediates
  localparam op17_t OP17_ADD_W  = 17'h00020;
  localparam op17_t OP17_SUB_W  = 17'h00022;
  localparam op17_t OP17_SLT    = 17'h00024;
  localparam op17_t OP17_SLTU   = 17'h00025;
  localparam op17_t OP17_NOR    = 17'h00028;
  localparam op17_t OP17_AND    = 17'h00029;
  localparam op17_t OP17_OR     = 17'h0002a;
  localparam op17_t OP17_XOR    = 17'h0002b;
  localparam op17_t OP17_SLL_W  = 17'h0002e;
  localparam op17_t OP17_SRL_W  = 17'h0002f;
  localparam op17_t OP17_SRA_W  = 17'h00030;
  localparam op17_t OP17_SLLI_W = 17'h00081;
  localparam op17_t OP17_SRLI_W = 17'h00089;
  localparam op17_t OP17_SRAI_W = 17'h00091;

  // Return address register written by bl
  localparam reg_addr_t LINK_REG = 5'd1;

endpackage

`default_nettype wire

// File: pipe_pkg.sv
`default_nettype none

package pipe_pkg;

  typedef enum logic [5:0] {
    ALU_NOP, ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
    ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
    ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_LUI, ALU_PCADD,
    ALU_LD_B, ALU_LD_H, ALU_LD_W, ALU_LD_BU, ALU_LD_HU,
    ALU_ST_B, ALU_ST_H, ALU_ST_W,
    ALU_JUMP_LINK, ALU_BRANCH
  } alu_op_e;

  typedef enum logic [2:0] {
    SEL_NOP, SEL_LOGIC, SEL_SHIFT, SEL_ARITH, SEL_MOVE, SEL_LOAD_STORE, SEL_JUMP
  } alu_sel_e;

  typedef enum logic [3:0] {
    BR_NONE, BR_B, BR_BL, BR_JIRL, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU
  } br_kind_e;

  // Result bypass from a later stage
  typedef struct packed {
    logic              wreg;
    isa_pkg::reg_addr_t waddr;
    isa_pkg::word_t    wdata;
  } fwd_t;

  typedef struct packed {
    logic               valid;
    alu_op_e            alu_op;
    alu_sel_e           alu_sel;
    br_kind_e           br_kind;
    logic               rd1_en;
    logic               rd2_en;
    isa_pkg::reg_addr_t rd1_addr;
    isa_pkg::reg_addr_t rd2_addr;
    logic               wreg;
    isa_pkg::reg_addr_t waddr;
    isa_pkg::word_t     imm;
  } dec_t;

  typedef struct packed {
    logic               valid;
    alu_op_e            alu_op;
    alu_sel_e           alu_sel;
    isa_pkg::word_t     op1;
    isa_pkg::word_t     op2;
    isa_pkg::word_t     store_data;
    logic               wreg;
    isa_pkg::reg_addr_t waddr;
    isa_pkg::word_t     pc;
    isa_pkg::word_t     link_addr;
  } id_ex_t;

endpackage

`default_nettype wire

// File: inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
  input  isa_pkg::inst_t inst_i,
  input  logic           valid_i,
  output pipe_pkg::dec_t dec_o
);

  isa_pkg::op6_t      op6;
  isa_pkg::op7_t      op7;
  isa_pkg::op10_t     op10;
  isa_pkg::op17_t     op17;
  isa_pkg::reg_addr_t rd;
  isa_pkg::reg_addr_t rj;
  isa_pkg::reg_addr_t rk;
  logic [11:0]        imm12;
  logic [19:0]        imm20;

  pipe_pkg::alu_op_e  op17_op;
  pipe_pkg::alu_op_e  op10_op;
  pipe_pkg::br_kind_e op6_br;
  logic               shift_imm;
  logic               zext12;
  logic               is_store;

  assign op6   = inst_i[isa_pkg::OP6_LSB +: $bits(isa_pkg::op6_t)];
  assign op7   = inst_i[isa_pkg::OP7_LSB +: $bits(isa_pkg::op7_t)];
  assign op10  = inst_i[isa_pkg::OP10_LSB +: $bits(isa_pkg::op10_t)];
  assign op17  = inst_i[isa_pkg::OP17_LSB +: $bits(isa_pkg::op17_t)];
  assign rd    = inst_i[isa_pkg::RD_LSB +: 5];
  assign rj    = inst_i[isa_pkg::RJ_LSB +: 5];
  assign rk    = inst_i[isa_pkg::RK_LSB +: 5];
  assign imm12 = inst_i[isa_pkg::IMM12_LSB +: 12];
  assign imm20 = inst_i[isa_pkg::IMM20_LSB +: 20];

  assign shift_imm = op17 inside {isa_pkg::OP17_SLLI_W, isa_pkg::OP17_SRLI_W,
                                  isa_pkg::OP17_SRAI_W};
  assign zext12    = op10 inside {isa_pkg::OP10_ANDI, isa_pkg::OP10_ORI, isa_pkg::OP10_XORI};
  assign is_store  = op10 inside {isa_pkg::OP10_ST_B, isa_pkg::OP10_ST_H, isa_pkg::OP10_ST_W};

  // ALU_NOP marks no match in each table
  always_comb
  begin
    case (op17)
      isa_pkg::OP17_ADD_W:  op17_op = pipe_pkg::ALU_ADD;
      isa_pkg::OP17_SUB_W:  op17_op = pipe_pkg::ALU_SUB;
      isa_pkg::OP17_SLT:    op17_op = pipe_pkg::ALU_SLT;
      isa_pkg::OP17_SLTU:   op17_op = pipe_pkg::ALU_SLTU;
      isa_pkg::OP17_NOR:    op17_op = pipe_pkg::ALU_NOR;
      isa_pkg::OP17_AND:    op17_op = pipe_pkg::ALU_AND;
      isa_pkg::OP17_OR:     op17_op = pipe_pkg::ALU_OR;
      isa_pkg::OP17_XOR:    op17_op = pipe_pkg::ALU_XOR;
      isa_pkg::OP17_SLL_W:  op17_op = pipe_pkg::ALU_SLL;
      isa_pkg::OP17_SRL_W:  op17_op = pipe_pkg::ALU_SRL;
      isa_pkg::OP17_SRA_W:  op17_op = pipe_pkg::ALU_SRA;
      isa_pkg::OP17_SLLI_W: op17_op = pipe_pkg::ALU_SLL;
      isa_pkg::OP17_SRLI_W: op17_op = pipe_pkg::ALU_SRL;
      isa_pkg::OP17_SRAI_W: op17_op = pipe_pkg::ALU_SRA;
      default:              op17_op = pipe_pkg::ALU_NOP;
    endcase
  end

  always_comb
  begin
    case (op10)
      isa_pkg::OP10_SLTI:   op10_op = pipe_pkg::ALU_SLT;
      isa_pkg::OP10_SLTUI:  op10_op = pipe_pkg::ALU_SLTU;
      isa_pkg::OP10_ADDI_W: op10_op = pipe_pkg::ALU_ADD;
      isa_pkg::OP10_ANDI:   op10_op = pipe_pkg::ALU_AND;
      isa_pkg::OP10_ORI:    op10_op = pipe_pkg::ALU_OR;
      isa_pkg::OP10_XORI:   op10_op = pipe_pkg::ALU_XOR;
      isa_pkg::OP10_LD_B:   op10_op = pipe_pkg::ALU_LD_B;
      isa_pkg::OP10_LD_H:   op10_op = pipe_pkg::ALU_LD_H;
      isa_pkg::OP10_LD_W:   op10_op = pipe_pkg::ALU_LD_W;
      isa_pkg::OP10_LD_BU:  op10_op = pipe_pkg::ALU_LD_BU;
      isa_pkg::OP10_LD_HU:  op10_op = pipe_pkg::ALU_LD_HU;
      isa_pkg::OP10_ST_B:   op10_op = pipe_pkg::ALU_ST_B;
      isa_pkg::OP10_ST_H:   op10_op = pipe_pkg::ALU_ST_H;
      isa_pkg::OP10_ST_W:   op10_op = pipe_pkg::ALU_ST_W;
      default:              op10_op = pipe_pkg::ALU_NOP;
    endcase
  end

  always_comb
  begin
    case (op6)
      isa_pkg::OP6_JIRL: op6_br = pipe_pkg::BR_JIRL;
      isa_pkg::OP6_B:    op6_br = pipe_pkg::BR_B;
      isa_pkg::OP6_BL:   op6_br = pipe_pkg::BR_BL;
      isa_pkg::OP6_BEQ:  op6_br = pipe_pkg::BR_BEQ;
      isa_pkg::OP6_BNE:  op6_br = pipe_pkg::BR_BNE;
      isa_pkg::OP6_BLT:  op6_br = pipe_pkg::BR_BLT;
      isa_pkg::OP6_BGE:  op6_br = pipe_pkg::BR_BGE;
      isa_pkg::OP6_BLTU: op6_br = pipe_pkg::BR_BLTU;
      isa_pkg::OP6_BGEU: op6_br = pipe_pkg::BR_BGEU;
      default:           op6_br = pipe_pkg::BR_NONE;
    endcase
  end

  function automatic pipe_pkg::alu_sel_e sel_of(pipe_pkg::alu_op_e op);
    case (op)
      pipe_pkg::ALU_ADD, pipe_pkg::ALU_SUB,
      pipe_pkg::ALU_SLT, pipe_pkg::ALU_SLTU:  return pipe_pkg::SEL_ARITH;
      pipe_pkg::ALU_AND, pipe_pkg::ALU_OR,
      pipe_pkg::ALU_XOR, pipe_pkg::ALU_NOR:   return pipe_pkg::SEL_LOGIC;
      pipe_pkg::ALU_SLL, pipe_pkg::ALU_SRL,
      pipe_pkg::ALU_SRA:                      return pipe_pkg::SEL_SHIFT;
      pipe_pkg::ALU_LUI, pipe_pkg::ALU_PCADD: return pipe_pkg::SEL_MOVE;
      pipe_pkg::ALU_JUMP_LINK,
      pipe_pkg::ALU_BRANCH:                   return pipe_pkg::SEL_JUMP;
      pipe_pkg::ALU_NOP:                      return pipe_pkg::SEL_NOP;
      default:                                return pipe_pkg::SEL_LOAD_STORE;
    endcase
  endfunction

  // Widest opcode field wins
  always_comb
  begin
    dec_o          = '0;
    dec_o.rd1_addr = rj;
    dec_o.rd2_addr = rk;
    dec_o.waddr    = rd;
    if (op17_op != pipe_pkg::ALU_NOP)
    begin
      dec_o.alu_op = op17_op;
      dec_o.rd1_en = 1'b1;
      dec_o.wreg   = 1'b1;
      // ui5 sits in the rk field
      if (shift_imm)
        dec_o.imm = {27'b0, rk};
      else
        dec_o.rd2_en = 1'b1;
    end
    else if (op10_op != pipe_pkg::ALU_NOP)
    begin
      dec_o.alu_op = op10_op;
      dec_o.rd1_en = 1'b1;
      dec_o.imm    = zext12 ? {20'b0, imm12} : {{20{imm12[11]}}, imm12};
      if (is_store)
      begin
        dec_o.rd2_en   = 1'b1;
        dec_o.rd2_addr = rd;
      end
      else
        dec_o.wreg = 1'b1;
    end
    else if (op7 == isa_pkg::OP7_LU12I_W || op7 == isa_pkg::OP7_PCADDU12I)
    begin
      dec_o.alu_op = (op7 == isa_pkg::OP7_LU12I_W) ? pipe_pkg::ALU_LUI : pipe_pkg::ALU_PCADD;
      dec_o.imm    = {imm20, 12'b0};
      dec_o.wreg   = 1'b1;
    end
    else if (op6_br != pipe_pkg::BR_NONE)
    begin
      dec_o.br_kind = op6_br;
      dec_o.alu_op  = pipe_pkg::ALU_BRANCH;
      if (op6_br == pipe_pkg::BR_BL)
      begin
        dec_o.alu_op = pipe_pkg::ALU_JUMP_LINK;
        dec_o.wreg   = 1'b1;
        dec_o.waddr  = isa_pkg::LINK_REG;
      end
      else if (op6_br == pipe_pkg::BR_JIRL)
      begin
        dec_o.alu_op = pipe_pkg::ALU_JUMP_LINK;
        dec_o.rd1_en = 1'b1;
        dec_o.wreg   = 1'b1;
      end
      else if (op6_br != pipe_pkg::BR_B)
      begin
        // Compare rj against rd
        dec_o.rd1_en   = 1'b1;
        dec_o.rd2_en   = 1'b1;
        dec_o.rd2_addr = rd;
      end
    end
    dec_o.alu_sel = sel_of(dec_o.alu_op);
    dec_o.valid   = valid_i && (dec_o.alu_op != pipe_pkg::ALU_NOP);
  end

endmodule

`default_nettype wire

// File: operand_mux.sv
`timescale 1ns/1ps
`default_nettype none

module operand_mux (
  input  logic               rd_en_i,
  input  isa_pkg::reg_addr_t rd_addr_i,
  input  isa_pkg::word_t     rf_rdata_i,
  input  isa_pkg::word_t     imm_i,
  input  pipe_pkg::fwd_t     ex_fwd_i,
  input  pipe_pkg::fwd_t     mem_fwd_i,
  output isa_pkg::word_t     operand_o
);

  // r0 first, then the youngest producer
  always_comb
  begin
    if (!rd_en_i)
      operand_o = imm_i;
    else if (rd_addr_i == '0)
      operand_o = '0;
    else if (ex_fwd_i.wreg && ex_fwd_i.waddr == rd_addr_i)
      operand_o = ex_fwd_i.wdata;
    else if (mem_fwd_i.wreg && mem_fwd_i.waddr == rd_addr_i)
      operand_o = mem_fwd_i.wdata;
    else
      operand_o = rf_rdata_i;
  end

endmodule

`default_nettype wire

// File: branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
  input  pipe_pkg::dec_t dec_i,
  input  isa_pkg::word_t pc_i,
  input  isa_pkg::word_t op1_i,
  input  isa_pkg::word_t op2_i,
  input  isa_pkg::inst_t inst_i,
  input  logic           stall_i,
  output logic           branch_flag_o,
  output isa_pkg::word_t branch_target_o,
  output isa_pkg::word_t link_addr_o
);

  logic [15:0]    imm16;
  logic [9:0]     imm10;
  isa_pkg::word_t off16;
  isa_pkg::word_t off26;
  isa_pkg::word_t target;
  logic           taken;

  assign imm16 = inst_i[isa_pkg::IMM16_LSB +: 16];
  assign imm10 = inst_i[isa_pkg::IMM10_LSB +: 10];
  assign off16 = {{14{imm16[15]}}, imm16, 2'b00};
  assign off26 = {{4{imm10[9]}}, imm10, imm16, 2'b00};

  always_comb
  begin
    taken  = 1'b0;
    target = pc_i + off16;
    case (dec_i.br_kind)
      pipe_pkg::BR_B, pipe_pkg::BR_BL:
      begin
        taken  = 1'b1;
        target = pc_i + off26;
      end
      pipe_pkg::BR_JIRL:
      begin
        taken  = 1'b1;
        target = op1_i + off16;
      end
      pipe_pkg::BR_BEQ:  taken = (op1_i == op2_i);
      pipe_pkg::BR_BNE:  taken = (op1_i != op2_i);
      pipe_pkg::BR_BLT:  taken = ($signed(op1_i) < $signed(op2_i));
      pipe_pkg::BR_BGE:  taken = ($signed(op1_i) >= $signed(op2_i));
      pipe_pkg::BR_BLTU: taken = (op1_i < op2_i);
      pipe_pkg::BR_BGEU: taken = (op1_i >= op2_i);
      default:           taken = 1'b0;
    endcase
  end

  assign branch_flag_o   = dec_i.valid && !stall_i && taken;
  assign branch_target_o = branch_flag_o ? target : '0;
  assign link_addr_o     = (dec_i.br_kind == pipe_pkg::BR_BL || dec_i.br_kind == pipe_pkg::BR_JIRL)
                         ? pc_i + 32'd4 : '0;

endmodule

`default_nettype wire

// File: id_ex_reg.sv
`timescale 1ns/1ps
`default_nettype none

module id_ex_reg (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  pipe_pkg::dec_t   dec_i,
  input  isa_pkg::word_t   pc_i,
  input  isa_pkg::word_t   op1_i,
  input  isa_pkg::word_t   op2_i,
  input  isa_pkg::word_t   link_addr_i,
  input  pipe_pkg::fwd_t   ex_fwd_i,
  input  logic             ex_load_i,
  output logic             stall_o,
  output pipe_pkg::id_ex_t id_ex_o
);

  logic             hit1;
  logic             hit2;
  logic             is_store;
  pipe_pkg::id_ex_t id_ex_d;

  // Load in ex whose result is a source here
  assign hit1     = dec_i.rd1_en && (ex_fwd_i.waddr == dec_i.rd1_addr);
  assign hit2     = dec_i.rd2_en && (ex_fwd_i.waddr == dec_i.rd2_addr);
  assign stall_o  = dec_i.valid && ex_load_i && (ex_fwd_i.waddr != '0) && (hit1 || hit2);
  assign is_store = dec_i.alu_op inside {pipe_pkg::ALU_ST_B, pipe_pkg::ALU_ST_H,
                                         pipe_pkg::ALU_ST_W};

  always_comb
  begin
    id_ex_d = '0;
    if (dec_i.valid && !stall_o)
    begin
      id_ex_d.valid     = 1'b1;
      id_ex_d.alu_op    = dec_i.alu_op;
      id_ex_d.alu_sel   = dec_i.alu_sel;
      id_ex_d.op1       = op1_i;
      id_ex_d.wreg      = dec_i.wreg;
      id_ex_d.waddr     = dec_i.waddr;
      id_ex_d.pc        = pc_i;
      id_ex_d.link_addr = link_addr_i;
      // Store data comes through read port 2, the offset goes to op2
      if (is_store)
      begin
        id_ex_d.op2        = dec_i.imm;
        id_ex_d.store_data = op2_i;
      end
      else
        id_ex_d.op2 = op2_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      id_ex_o <= '0;
    else
      id_ex_o <= id_ex_d;
  end

endmodule

`default_nettype wire

// File: id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  isa_pkg::word_t     if_pc_i,
  input  isa_pkg::inst_t     if_inst_i,
  input  logic               if_valid_i,
  input  isa_pkg::word_t     rf_rdata1_i,
  input  isa_pkg::word_t     rf_rdata2_i,
  input  pipe_pkg::fwd_t     ex_fwd_i,
  input  pipe_pkg::fwd_t     mem_fwd_i,
  input  logic               ex_load_i,
  output logic               rf_re1_o,
  output logic               rf_re2_o,
  output isa_pkg::reg_addr_t rf_raddr1_o,
  output isa_pkg::reg_addr_t rf_raddr2_o,
  output logic               branch_flag_o,
  output isa_pkg::word_t     branch_target_o,
  output logic               stall_o,
  output pipe_pkg::id_ex_t   id_ex_o
);

  pipe_pkg::dec_t dec;
  isa_pkg::word_t op1;
  isa_pkg::word_t op2;
  isa_pkg::word_t link_addr;

  assign rf_re1_o    = dec.rd1_en;
  assign rf_re2_o    = dec.rd2_en;
  assign rf_raddr1_o = dec.rd1_addr;
  assign rf_raddr2_o = dec.rd2_addr;

  inst_decoder u_dec (
    .inst_i  (if_inst_i),
    .valid_i (if_valid_i),
    .dec_o   (dec)
  );

  operand_mux u_opnd1 (
    .rd_en_i    (dec.rd1_en),
    .rd_addr_i  (dec.rd1_addr),
    .rf_rdata_i (rf_rdata1_i),
    .imm_i      (dec.imm),
    .ex_fwd_i   (ex_fwd_i),
    .mem_fwd_i  (mem_fwd_i),
    .operand_o  (op1)
  );

  operand_mux u_opnd2 (
    .rd_en_i    (dec.rd2_en),
    .rd_addr_i  (dec.rd2_addr),
    .rf_rdata_i (rf_rdata2_i),
    .imm_i      (dec.imm),
    .ex_fwd_i   (ex_fwd_i),
    .mem_fwd_i  (mem_fwd_i),
    .operand_o  (op2)
  );

  branch_unit u_branch (
    .dec_i           (dec),
    .pc_i            (if_pc_i),
    .op1_i           (op1),
    .op2_i           (op2),
    .inst_i          (if_inst_i),
    .stall_i         (stall_o),
    .branch_flag_o   (branch_flag_o),
    .branch_target_o (branch_target_o),
    .link_addr_o     (link_addr)
  );

  id_ex_reg u_id_ex (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .dec_i       (dec),
    .pc_i        (if_pc_i),
    .op1_i       (op1),
    .op2_i       (op2),
    .link_addr_i (link_addr),
    .ex_fwd_i    (ex_fwd_i),
    .ex_load_i   (ex_load_i),
    .stall_o     (stall_o),
    .id_ex_o     (id_ex_o)
  );

endmodule

`default_nettype wire

// File: id_stage_chk.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage_chk (
  input logic             clk_i,
  input logic             rst_n_i,
  input logic             stall_o,
  input logic             ex_load_i,
  input logic             branch_flag_o,
  input pipe_pkg::id_ex_t id_ex_o
);

  stall_needs_load: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    stall_o |-> ex_load_i)
    else $error("stall without a load in ex");

  // The stalled slot becomes a bubble
  bubble_after_stall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    stall_o |=> !id_ex_o.valid)
    else $error("valid micro-op after a stall");

  no_branch_in_stall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    stall_o |-> !branch_flag_o)
    else $error("branch taken during a stall");

  store_no_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (id_ex_o.valid && id_ex_o.alu_op inside {pipe_pkg::ALU_ST_B, pipe_pkg::ALU_ST_H,
                                             pipe_pkg::ALU_ST_W}) |-> !id_ex_o.wreg)
    else $error("store writes a register");

endmodule

bind id_stage id_stage_chk i_chk (
  .clk_i         (clk_i),
  .rst_n_i       (rst_n_i),
  .stall_o       (stall_o),
  .ex_load_i     (ex_load_i),
  .branch_flag_o (branch_flag_o),
  .id_ex_o       (id_ex_o)
);

`default_nettype wire

// File: tb_id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_id_stage;

  // Reset, alu, forwarding, branches, load-use and memory tests in clock cycles
  localparam int TEST_CYCLES = 11 + 40 + 4 + 15 + 4 + 6;

  logic               clk_i;
  logic               rst_n_i;
  isa_pkg::word_t     if_pc_i;
  isa_pkg::inst_t     if_inst_i;
  logic               if_valid_i;
  isa_pkg::word_t     rf_rdata1_i;
  isa_pkg::word_t     rf_rdata2_i;
  pipe_pkg::fwd_t     ex_fwd_i;
  pipe_pkg::fwd_t     mem_fwd_i;
  logic               ex_load_i;
  logic               rf_re1_o;
  logic               rf_re2_o;
  isa_pkg::reg_addr_t rf_raddr1_o;
  isa_pkg::reg_addr_t rf_raddr2_o;
  logic               branch_flag_o;
  isa_pkg::word_t     branch_target_o;
  logic               stall_o;
  pipe_pkg::id_ex_t   id_ex_o;

  isa_pkg::word_t rf [32];
  logic [31:0]    rng = 32'hd342a88f;

  isa_pkg::op17_t r3_ops [11] = '{isa_pkg::OP17_ADD_W, isa_pkg::OP17_SUB_W, isa_pkg::OP17_SLT,
    isa_pkg::OP17_SLTU, isa_pkg::OP17_NOR, isa_pkg::OP17_AND, isa_pkg::OP17_OR,
    isa_pkg::OP17_XOR, isa_pkg::OP17_SLL_W, isa_pkg::OP17_SRL_W, isa_pkg::OP17_SRA_W};
  isa_pkg::op17_t sh_ops [3] = '{isa_pkg::OP17_SLLI_W, isa_pkg::OP17_SRLI_W,
    isa_pkg::OP17_SRAI_W};
  isa_pkg::op10_t i12_ops [6] = '{isa_pkg::OP10_SLTI, isa_pkg::OP10_SLTUI,
    isa_pkg::OP10_ADDI_W, isa_pkg::OP10_ANDI, isa_pkg::OP10_ORI, isa_pkg::OP10_XORI};

  id_stage i_dut (.*);

  assign rf_rdata1_i = rf[rf_raddr1_o];
  assign rf_rdata2_i = rf[rf_raddr2_o];

  always #20 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic isa_pkg::inst_t enc_r3(isa_pkg::op17_t op, isa_pkg::reg_addr_t rk,
                                            isa_pkg::reg_addr_t rj, isa_pkg::reg_addr_t rd);
    return {op, rk, rj, rd};
  endfunction

  function automatic isa_pkg::inst_t enc_i12(isa_pkg::op10_t op, logic [11:0] imm,
                                             isa_pkg::reg_addr_t rj, isa_pkg::reg_addr_t rd);
    return {op, imm, rj, rd};
  endfunction

  function automatic isa_pkg::inst_t enc_br(isa_pkg::op6_t op, logic [15:0] imm,
                                            isa_pkg::reg_addr_t rj, isa_pkg::reg_addr_t rd);
    return {op, imm, rj, rd};
  endfunction

  function automatic pipe_pkg::alu_sel_e group_of(pipe_pkg::alu_op_e op);
    case (op)
      pipe_pkg::ALU_ADD, pipe_pkg::ALU_SUB, pipe_pkg::ALU_SLT,
      pipe_pkg::ALU_SLTU:                     return pipe_pkg::SEL_ARITH;
      pipe_pkg::ALU_AND, pipe_pkg::ALU_OR, pipe_pkg::ALU_XOR,
      pipe_pkg::ALU_NOR:                      return pipe_pkg::SEL_LOGIC;
      pipe_pkg::ALU_SLL, pipe_pkg::ALU_SRL,
      pipe_pkg::ALU_SRA:                      return pipe_pkg::SEL_SHIFT;
      pipe_pkg::ALU_LUI, pipe_pkg::ALU_PCADD: return pipe_pkg::SEL_MOVE;
      pipe_pkg::ALU_NOP:                      return pipe_pkg::SEL_NOP;
      default:                                return pipe_pkg::SEL_LOAD_STORE;
    endcase
  endfunction

  // Expected micro-op with operands straight from the register-file model
  function automatic pipe_pkg::id_ex_t ref_decode(isa_pkg::inst_t inst, isa_pkg::word_t pc);
    pipe_pkg::id_ex_t e;
    e          = '0;
    e.valid    = 1'b1;
    e.pc       = pc;
    e.wreg     = 1'b1;
    e.waddr    = inst[4:0];
    e.op1      = rf[inst[9:5]];
    e.op2      = rf[inst[14:10]];
    case (inst[31:15])
      isa_pkg::OP17_ADD_W:  e.alu_op = pipe_pkg::ALU_ADD;
      isa_pkg::OP17_SUB_W:  e.alu_op = pipe_pkg::ALU_SUB;
      isa_pkg::OP17_SLT:    e.alu_op = pipe_pkg::ALU_SLT;
      isa_pkg::OP17_SLTU:   e.alu_op = pipe_pkg::ALU_SLTU;
      isa_pkg::OP17_NOR:    e.alu_op = pipe_pkg::ALU_NOR;
      isa_pkg::OP17_AND:    e.alu_op = pipe_pkg::ALU_AND;
      isa_pkg::OP17_OR:     e.alu_op = pipe_pkg::ALU_OR;
      isa_pkg::OP17_XOR:    e.alu_op = pipe_pkg::ALU_XOR;
      isa_pkg::OP17_SLL_W, isa_pkg::OP17_SLLI_W: e.alu_op = pipe_pkg::ALU_SLL;
      isa_pkg::OP17_SRL_W, isa_pkg::OP17_SRLI_W: e.alu_op = pipe_pkg::ALU_SRL;
      isa_pkg::OP17_SRA_W, isa_pkg::OP17_SRAI_W: e.alu_op = pipe_pkg::ALU_SRA;
      default:
      begin
        e.op2 = {{20{inst[21]}}, inst[21:10]};
        case (inst[31:22])
          isa_pkg::OP10_SLTI:   e.alu_op = pipe_pkg::ALU_SLT;
          isa_pkg::OP10_SLTUI:  e.alu_op = pipe_pkg::ALU_SLTU;
          isa_pkg::OP10_ADDI_W: e.alu_op = pipe_pkg::ALU_ADD;
          isa_pkg::OP10_ANDI:   e.alu_op = pipe_pkg::ALU_AND;
          isa_pkg::OP10_ORI:    e.alu_op = pipe_pkg::ALU_OR;
          isa_pkg::OP10_XORI:   e.alu_op = pipe_pkg::ALU_XOR;
          isa_pkg::OP10_LD_B:   e.alu_op = pipe_pkg::ALU_LD_B;
          isa_pkg::OP10_LD_H:   e.alu_op = pipe_pkg::ALU_LD_H;
          isa_pkg::OP10_LD_W:   e.alu_op = pipe_pkg::ALU_LD_W;
          isa_pkg::OP10_LD_BU:  e.alu_op = pipe_pkg::ALU_LD_BU;
          isa_pkg::OP10_LD_HU:  e.alu_op = pipe_pkg::ALU_LD_HU;
          isa_pkg::OP10_ST_B:   e.alu_op = pipe_pkg::ALU_ST_B;
          isa_pkg::OP10_ST_H:   e.alu_op = pipe_pkg::ALU_ST_H;
          isa_pkg::OP10_ST_W:   e.alu_op = pipe_pkg::ALU_ST_W;
          default:
          begin
            // Upper immediates read nothing so both operands are the immediate
            e.op1 = {inst[24:5], 12'b0};
            e.op2 = e.op1;
            if (inst[31:25] == isa_pkg::OP7_LU12I_W)
              e.alu_op = pipe_pkg::ALU_LUI;
            else
              e.alu_op = pipe_pkg::ALU_PCADD;
          end
        endcase
      end
    endcase
    if (inst[31:15] inside {isa_pkg::OP17_SLLI_W, isa_pkg::OP17_SRLI_W, isa_pkg::OP17_SRAI_W})
      e.op2 = {27'b0, inst[14:10]};
    if (inst[31:22] inside {isa_pkg::OP10_ANDI, isa_pkg::OP10_ORI, isa_pkg::OP10_XORI})
      e.op2 = {20'b0, inst[21:10]};
    if (e.alu_op inside {pipe_pkg::ALU_ST_B, pipe_pkg::ALU_ST_H, pipe_pkg::ALU_ST_W})
    begin
      e.wreg       = 1'b0;
      e.store_data = rf[inst[4:0]];
    end
    e.alu_sel = group_of(e.alu_op);
    return e;
  endfunction

  task automatic stop_run();
    $display("** FAIL **");
    $fatal(1, "check failed");
  endtask

  task automatic check_word(string name, isa_pkg::word_t exp, isa_pkg::word_t act);
    if (exp !== act)
    begin
      $display("error %s expected %h actual %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (exp !== act)
    begin
      $display("error %s expected %h actual %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_op(string name, pipe_pkg::alu_op_e exp, pipe_pkg::alu_op_e act);
    if (exp !== act)
    begin
      $display("error %s expected %h actual %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_id_ex(pipe_pkg::id_ex_t exp, pipe_pkg::id_ex_t act);
    check_bit("id_ex.valid", exp.valid, act.valid);
    check_op("id_ex.alu_op", exp.alu_op, act.alu_op);
    check_word("id_ex.alu_sel", 32'(exp.alu_sel), 32'(act.alu_sel));
    check_word("id_ex.op1", exp.op1, act.op1);
    check_word("id_ex.op2", exp.op2, act.op2);
    check_word("id_ex.store_data", exp.store_data, act.store_data);
    check_bit("id_ex.wreg", exp.wreg, act.wreg);
    check_word("id_ex.waddr", 32'(exp.waddr), 32'(act.waddr));
    check_word("id_ex.pc", exp.pc, act.pc);
    check_word("id_ex.link_addr", exp.link_addr, act.link_addr);
  endtask

  // Drive one instruction and let the decode settle
  task automatic present(isa_pkg::inst_t inst, isa_pkg::word_t pc);
    if_inst_i  = inst;
    if_pc_i    = pc;
    if_valid_i = 1'b1;
    #5;
  endtask

  task automatic run_decoded(isa_pkg::inst_t inst, isa_pkg::word_t pc);
    pipe_pkg::id_ex_t exp;
    present(inst, pc);
    exp = ref_decode(inst, pc);
    @(negedge clk_i);
    check_id_ex(exp, id_ex_o);
  endtask

  task automatic test_reset();
    repeat (10)
    begin
      @(negedge clk_i);
      check_bit("id_ex.valid", 1'b0, id_ex_o.valid);
      check_bit("stall_o", 1'b0, stall_o);
      check_bit("branch_flag_o", 1'b0, branch_flag_o);
    end
    rst_n_i = 1'b1;
    @(negedge clk_i);
    check_id_ex('0, id_ex_o);
    check_bit("stall_o", 1'b0, stall_o);
    check_bit("branch_flag_o", 1'b0, branch_flag_o);
    ex_load_i = 1'b0;
    ex_fwd_i  = '0;
  endtask

  task automatic test_alu();
    logic [31:0] r;
    repeat (40)
    begin
      r = xorshift();
      case (r[1:0])
        2'd0:    run_decoded(enc_r3(r3_ops[r[5:2] % 11], r[10:6], r[15:11], r[20:16]), r);
        2'd1:    run_decoded(enc_r3(sh_ops[r[3:2] % 3], r[10:6], r[15:11], r[20:16]), r);
        default: run_decoded(enc_i12(i12_ops[r[4:2] % 6], r[31:20], r[15:11], r[9:5]), r);
      endcase
    end
  endtask

  task automatic test_forwarding();
    isa_pkg::inst_t inst;
    inst = enc_r3(isa_pkg::OP17_ADD_W, 5'd6, 5'd5, 5'd3);
    ex_fwd_i  = '{wreg: 1'b1, waddr: 5'd5, wdata: 32'ha5a5_0001};
    mem_fwd_i = '{wreg: 1'b1, waddr: 5'd5, wdata: 32'h5a5a_0002};
    present(inst, 32'h100);
    check_bit("rf_re1_o", 1'b1, rf_re1_o);
    check_bit("rf_re2_o", 1'b1, rf_re2_o);
    check_word("rf_raddr1_o", 32'd5, 32'(rf_raddr1_o));
    check_word("rf_raddr2_o", 32'd6, 32'(rf_raddr2_o));
    @(negedge clk_i);
    check_word("id_ex.op1", 32'ha5a5_0001, id_ex_o.op1);
    ex_fwd_i.wreg = 1'b0;
    present(inst, 32'h104);
    @(negedge clk_i);
    check_word("id_ex.op1", 32'h5a5a_0002, id_ex_o.op1);
    mem_fwd_i.wreg = 1'b0;
    present(inst, 32'h108);
    @(negedge clk_i);
    check_word("id_ex.op1", rf[5], id_ex_o.op1);
    ex_fwd_i = '{wreg: 1'b1, waddr: 5'd0, wdata: 32'hdead_beef};
    present(enc_r3(isa_pkg::OP17_ADD_W, 5'd6, 5'd0, 5'd3), 32'h10c);
    @(negedge clk_i);
    check_word("id_ex.op1", 32'h0, id_ex_o.op1);
    ex_fwd_i = '0;
  endtask

  task automatic run_branch(isa_pkg::op6_t op, isa_pkg::word_t a, isa_pkg::word_t b,
                            logic taken);
    rf[7] = a;
    rf[8] = b;
    present(enc_br(op, 16'hfff0, 5'd7, 5'd8), 32'h2000);
    check_bit("branch_flag_o", taken, branch_flag_o);
    check_word("branch_target_o", taken ? 32'h1fc0 : 32'h0, branch_target_o);
    @(negedge clk_i);
    check_bit("id_ex.valid", 1'b1, id_ex_o.valid);
    check_bit("id_ex.wreg", 1'b0, id_ex_o.wreg);
    check_word("id_ex.link_addr", 32'h0, id_ex_o.link_addr);
  endtask

  task automatic run_jump(isa_pkg::inst_t inst, isa_pkg::word_t target,
                          isa_pkg::reg_addr_t waddr);
    present(inst, 32'h3000);
    check_bit("branch_flag_o", 1'b1, branch_flag_o);
    check_word("branch_target_o", target, branch_target_o);
    @(negedge clk_i);
    check_word("id_ex.link_addr", 32'h3004, id_ex_o.link_addr);
    check_word("id_ex.waddr", 32'(waddr), 32'(id_ex_o.waddr));
  endtask

  task automatic test_branches();
    run_branch(isa_pkg::OP6_BEQ, 32'h5, 32'h5, 1'b1);
    run_branch(isa_pkg::OP6_BEQ, 32'h5, 32'h6, 1'b0);
    run_branch(isa_pkg::OP6_BNE, 32'h5, 32'h6, 1'b1);
    run_branch(isa_pkg::OP6_BNE, 32'h5, 32'h5, 1'b0);
    run_branch(isa_pkg::OP6_BLT, 32'hffff_fff0, 32'h1, 1'b1);
    run_branch(isa_pkg::OP6_BLT, 32'h1, 32'hffff_fff0, 1'b0);
    run_branch(isa_pkg::OP6_BGE, 32'h1, 32'hffff_fff0, 1'b1);
    run_branch(isa_pkg::OP6_BGE, 32'hffff_fff0, 32'h1, 1'b0);
    run_branch(isa_pkg::OP6_BLTU, 32'h1, 32'hffff_fff0, 1'b1);
    run_branch(isa_pkg::OP6_BLTU, 32'hffff_fff0, 32'h1, 1'b0);
    run_branch(isa_pkg::OP6_BGEU, 32'hffff_fff0, 32'h1, 1'b1);
    run_branch(isa_pkg::OP6_BGEU, 32'h1, 32'hffff_fff0, 1'b0);
    // b and bl take {imm10, imm16} from bits 9:0 and 25:10
    present({isa_pkg::OP6_B, 16'hff00, 10'h3ff}, 32'h3000);
    check_bit("branch_flag_o", 1'b1, branch_flag_o);
    check_word("branch_target_o", 32'h2c00, branch_target_o);
    @(negedge clk_i);
    run_jump({isa_pkg::OP6_BL, 16'h0040, 10'h000}, 32'h3100, isa_pkg::LINK_REG);
    rf[7] = 32'h0000_8000;
    run_jump(enc_br(isa_pkg::OP6_JIRL, 16'h0008, 5'd7, 5'd5), 32'h0000_8020, 5'd5);
  endtask

  task automatic test_load_use();
    ex_load_i = 1'b1;
    ex_fwd_i  = '{wreg: 1'b1, waddr: 5'd6, wdata: 32'h0};
    present(enc_r3(isa_pkg::OP17_ADD_W, 5'd6, 5'd5, 5'd3), 32'h400);
    check_bit("stall_o", 1'b1, stall_o);
    @(negedge clk_i);
    check_bit("id_ex.valid", 1'b0, id_ex_o.valid);
    check_op("id_ex.alu_op", pipe_pkg::ALU_NOP, id_ex_o.alu_op);
    ex_fwd_i.waddr = 5'd9;
    present(enc_r3(isa_pkg::OP17_ADD_W, 5'd6, 5'd5, 5'd3), 32'h400);
    check_bit("stall_o", 1'b0, stall_o);
    @(negedge clk_i);
    // rk field holds r6 but addi.w does not read it
    ex_fwd_i.waddr = 5'd6;
    present(enc_i12(isa_pkg::OP10_ADDI_W, 12'h186, 5'd5, 5'd3), 32'h404);
    check_bit("rf_re1_o", 1'b1, rf_re1_o);
    check_bit("rf_re2_o", 1'b0, rf_re2_o);
    check_bit("stall_o", 1'b0, stall_o);
    @(negedge clk_i);
    ex_fwd_i.waddr = 5'd0;
    present(enc_r3(isa_pkg::OP17_ADD_W, 5'd0, 5'd0, 5'd3), 32'h408);
    check_bit("stall_o", 1'b0, stall_o);
    @(negedge clk_i);
    check_bit("id_ex.valid", 1'b1, id_ex_o.valid);
    ex_load_i = 1'b0;
    ex_fwd_i  = '0;
  endtask

  task automatic test_mem_upper();
    run_decoded(enc_i12(isa_pkg::OP10_LD_W, 12'hff8, 5'd5, 5'd4), 32'h500);
    run_decoded(enc_i12(isa_pkg::OP10_LD_BU, 12'h7f0, 5'd2, 5'd4), 32'h504);
    run_decoded(enc_i12(isa_pkg::OP10_ST_W, 12'h7f0, 5'd5, 5'd9), 32'h508);
    run_decoded(enc_i12(isa_pkg::OP10_ST_B, 12'h801, 5'd3, 5'd12), 32'h50c);
    run_decoded({isa_pkg::OP7_LU12I_W, 20'h8_1234, 5'd7}, 32'h510);
    run_decoded({isa_pkg::OP7_PCADDU12I, 20'h0_00ab, 5'd8}, 32'h1234_5678);
  endtask

  initial
  begin
    #(TEST_CYCLES * 40 + 2000);
    $display("timeout: the tests did not finish in time");
    $display("** FAIL **");
    $fatal(1, "watchdog expired");
  end

  initial
  begin
    clk_i      = 1'b0;
    rst_n_i    = 1'b0;
    if_pc_i    = '0;
    // Idle jirl with a load in ex must neither branch nor stall
    if_inst_i  = enc_br(isa_pkg::OP6_JIRL, 16'h0008, 5'd7, 5'd5);
    if_valid_i = 1'b0;
    ex_fwd_i   = '{wreg: 1'b1, waddr: 5'd7, wdata: 32'h0};
    mem_fwd_i  = '0;
    ex_load_i  = 1'b1;
    rf[0]      = '0;
    for (int i = 1; i < 32; i++)
      rf[i] = xorshift();
    test_reset();
    test_alu();
    test_forwarding();
    test_branches();
    test_load_use();
    test_mem_upper();
    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
isa_pkg.sv
pipe_pkg.sv
inst_decoder.sv
operand_mux.sv
branch_unit.sv
id_ex_reg.sv
id_stage.sv
id_stage_chk.sv
tb_id_stage.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_id_stage -f project.f
./obj_dir/Vtb_id_stage
